// File: verilog/video_pkg.sv
`default_nettype none

package video_pkg;

	// raster position
	typedef logic [8:0] col_t;
	typedef logic [8:0] row_t;

	// palette index and CRAM entry, 0:R5:G5:B5
	typedef logic [7:0] colour_idx_t;
	typedef logic [14:0] cram_colour_t;

	// DRAM word address and data
	typedef logic [20:0] dram_addr_t;
	typedef logic [15:0] dram_word_t;

	// one DAC channel
	typedef logic [1:0] dac_t;

	// register values seen by the raster logic
	typedef struct packed {
		colour_idx_t border;
		// live copy, re-latched at frame start
		logic [7:0] vpage;
		// live copy, re-latched at line start
		logic [3:0] palsel;
		col_t hint_beg;
		row_t vint_beg;
	} video_regs_t;

	// raster position with its window flag and strobes
	typedef struct packed {
		col_t col;
		row_t row;
		logic hvpix;
		logic line_start;
		logic frame_start;
	} raster_t;

endpackage

`default_nettype wire

// File: verilog/video_ports.sv
`timescale 1ns/1ps
`default_nettype none

module video_ports (
	input wire clk,
	input wire arst_n,

	input wire [7:0] d,

	// Z80 port write strobes
	input wire border_wr,
	input wire vpage_wr,
	input wire palsel_wr,
	input wire hint_beg_wr,
	input wire vint_begl_wr,
	input wire vint_begh_wr,

	input wire line_start,
	input wire frame_start,

	output video_pkg::video_regs_t regs
);

	// Z80-side copies, moved to the live ones at the raster strobes
	logic [7:0] vpage_z;
	logic [3:0] palsel_z;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			regs <= '0;
			vpage_z <= '0;
			palsel_z <= '0;
		end else begin
			if (border_wr)
				regs.border <= d;
			if (vpage_wr)
				vpage_z <= d;
			if (palsel_wr)
				palsel_z <= d[3:0];
			if (hint_beg_wr)
				regs.hint_beg <= {1'b0, d};

			// vint_beg comes in two halves
			if (vint_begl_wr)
				regs.vint_beg[7:0] <= d;
			if (vint_begh_wr)
				regs.vint_beg[8] <= d[0];

			// no tearing on mid-frame writes
			if (frame_start)
				regs.vpage <= vpage_z;
			if (line_start)
				regs.palsel <= palsel_z;
		end
	end

endmodule

`default_nettype wire

// File: verilog/video_sync.sv
`timescale 1ns/1ps
`default_nettype none

module video_sync #(
	parameter int h_total = 64,
	parameter int h_sync = 4,
	parameter int hpix_beg = 16,
	parameter int hpix_end = 48,
	parameter int v_total = 24,
	parameter int v_sync = 2,
	parameter int vpix_beg = 6,
	parameter int vpix_end = 18
) (
	input wire clk,
	input wire arst_n,

	input wire video_pkg::video_regs_t regs,

	output video_pkg::raster_t raster,

	output wire hsync,
	output wire vsync,
	output wire csync,
	output wire int_start
);

	video_pkg::col_t col;
	video_pkg::row_t row;

	logic hpix;
	logic vpix;
	logic line_start;
	logic frame_start;
	logic hsync_c;
	logic vsync_c;
	logic int_c;

	// {int, csync, vsync, hsync} per stage
	logic [2:0][3:0] dly;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			col <= '0;
			row <= '0;
		end else if (col == video_pkg::col_t'(h_total - 1)) begin
			col <= '0;
			if (row == video_pkg::row_t'(v_total - 1))
				row <= '0;
			else
				row <= row + 1'b1;
		end else begin
			col <= col + 1'b1;
		end
	end

	assign hpix = col >= video_pkg::col_t'(hpix_beg) && col < video_pkg::col_t'(hpix_end);
	assign vpix = row >= video_pkg::row_t'(vpix_beg) && row < video_pkg::row_t'(vpix_end);

	assign line_start = col == '0;
	assign frame_start = line_start && row == '0;

	// syncs low from column 0 and line 0
	assign hsync_c = col >= video_pkg::col_t'(h_sync);
	assign vsync_c = row >= video_pkg::row_t'(v_sync);
	assign int_c = row == regs.vint_beg && col == regs.hint_beg;

	// match the 3-cycle pixel path to the DAC
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			dly <= {3{4'b0111}};
		else
			dly <= {dly[1:0], {int_c, hsync_c & vsync_c, vsync_c, hsync_c}};
	end

	assign hsync = dly[2][0];
	assign vsync = dly[2][1];
	assign csync = dly[2][2];
	assign int_start = dly[2][3];

	assign raster = '{
		col: col,
		row: row,
		hvpix: hpix && vpix,
		line_start: line_start,
		frame_start: frame_start
	};

endmodule

`default_nettype wire

// File: verilog/video_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module video_fetch #(
	parameter int hpix_beg = 16,
	parameter int hpix_end = 48,
	parameter int vpix_beg = 6,
	parameter int vpix_end = 18
) (
	input wire clk,
	input wire arst_n,

	input wire video_pkg::raster_t raster,
	input wire video_pkg::video_regs_t regs,

	// DRAM side
	output logic video_go,
	output video_pkg::dram_addr_t video_addr,
	input wire video_strobe,
	input wire video_pkg::dram_word_t dram_rddata,

	output video_pkg::dram_word_t word
);

	// go rises one column after the request decision
	localparam video_pkg::col_t first_req = video_pkg::col_t'(hpix_beg - 9);
	localparam video_pkg::col_t next_beg = video_pkg::col_t'(hpix_beg - 1);
	localparam video_pkg::col_t next_end = video_pkg::col_t'(hpix_end - 9);

	logic vline;
	logic req;
	logic swap;
	logic [5:0] wcnt;
	video_pkg::col_t xpix;
	video_pkg::row_t yoff;
	video_pkg::dram_word_t nxt;

	assign vline = raster.row >= video_pkg::row_t'(vpix_beg) &&
		raster.row < video_pkg::row_t'(vpix_end);

	assign xpix = raster.col - video_pkg::col_t'(hpix_beg);
	assign yoff = raster.row - video_pkg::row_t'(vpix_beg);

	// first word 8 columns ahead, the rest 4 ahead
	assign req = vline && (raster.col == first_req ||
		(raster.col >= next_beg && raster.col <= next_end && xpix[1:0] == 2'd3));

	// start of each 4-pixel group
	assign swap = raster.hvpix && xpix[1:0] == 2'd0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			video_go <= 1'b0;
			video_addr <= '0;
			wcnt <= '0;
		end else begin
			if (raster.line_start)
				wcnt <= '0;
			else if (req)
				wcnt <= wcnt + 1'b1;

			// a new request may follow the strobe with no idle cycle
			if (req) begin
				video_go <= 1'b1;
				video_addr <= {regs.vpage, 13'd0} +
					video_pkg::dram_addr_t'({yoff, 6'd0}) +
					video_pkg::dram_addr_t'(wcnt);
			end else if (video_strobe) begin
				video_go <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (video_strobe)
			nxt <= dram_rddata;
		if (swap)
			word <= nxt;
	end

endmodule

`default_nettype wire

// File: verilog/video_render.sv
`timescale 1ns/1ps
`default_nettype none

module video_render (
	input wire clk,
	input wire arst_n,

	input wire video_pkg::raster_t raster,
	input wire video_pkg::video_regs_t regs,
	input wire video_pkg::dram_word_t word,

	output video_pkg::colour_idx_t index
);

	logic hvpix_q;
	logic [1:0] phase_q;
	logic [3:0] nibble;

	// phase restarts on each window entry
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hvpix_q <= 1'b0;
			phase_q <= '0;
		end else begin
			hvpix_q <= raster.hvpix;
			phase_q <= (raster.hvpix && hvpix_q) ? phase_q + 1'b1 : 2'd0;
		end
	end

	// leftmost pixel in the top nibble
	always_comb begin
		case (phase_q)
			2'd0: nibble = word[15:12];
			2'd1: nibble = word[11:8];
			2'd2: nibble = word[7:4];
			default: nibble = word[3:0];
		endcase
	end

	assign index = hvpix_q ? {regs.palsel, nibble} : regs.border;

endmodule

`default_nettype wire

// File: verilog/video_out.sv
`timescale 1ns/1ps
`default_nettype none

module video_out (
	input wire clk,
	input wire arst_n,

	input wire video_pkg::colour_idx_t index,

	// Z80 side CRAM write
	input wire cram_we,
	input wire [7:0] zma,
	input wire video_pkg::cram_colour_t zmd,

	output video_pkg::dac_t vred,
	output video_pkg::dac_t vgrn,
	output video_pkg::dac_t vblu
);

	video_pkg::cram_colour_t cram [256];
	video_pkg::cram_colour_t colour;

	// write port and registered read port
	always_ff @(posedge clk) begin
		if (cram_we)
			cram[zma] <= zmd;
		colour <= cram[index];
	end

	// top two bits of each 5-bit channel
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vred <= '0;
			vgrn <= '0;
			vblu <= '0;
		end else begin
			vred <= colour[14:13];
			vgrn <= colour[9:8];
			vblu <= colour[4:3];
		end
	end

endmodule

`default_nettype wire

// File: verilog/video_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_top #(
	parameter int h_total = 64,
	parameter int h_sync = 4,
	parameter int hpix_beg = 16,
	parameter int hpix_end = 48,
	parameter int v_total = 24,
	parameter int v_sync = 2,
	parameter int vpix_beg = 6,
	parameter int vpix_end = 18
) (
	input wire clk,
	input wire arst_n,

	// Z80 port writes
	input wire [7:0] d,
	input wire border_wr,
	input wire vpage_wr,
	input wire palsel_wr,
	input wire hint_beg_wr,
	input wire vint_begl_wr,
	input wire vint_begh_wr,

	// CRAM write
	input wire cram_we,
	input wire [7:0] zma,
	input wire video_pkg::cram_colour_t zmd,

	// DRAM
	output wire video_go,
	output wire video_pkg::dram_addr_t video_addr,
	input wire video_strobe,
	input wire video_pkg::dram_word_t dram_rddata,

	// syncs and DAC
	output wire hsync,
	output wire vsync,
	output wire csync,
	output wire int_start,
	output wire video_pkg::dac_t vred,
	output wire video_pkg::dac_t vgrn,
	output wire video_pkg::dac_t vblu
);

	video_pkg::video_regs_t regs;
	video_pkg::raster_t raster;
	video_pkg::dram_word_t word;
	video_pkg::colour_idx_t index;

	video_ports video_ports (
		.clk          (clk),
		.arst_n       (arst_n),
		.d            (d),
		.border_wr    (border_wr),
		.vpage_wr     (vpage_wr),
		.palsel_wr    (palsel_wr),
		.hint_beg_wr  (hint_beg_wr),
		.vint_begl_wr (vint_begl_wr),
		.vint_begh_wr (vint_begh_wr),
		.line_start   (raster.line_start),
		.frame_start  (raster.frame_start),
		.regs         (regs)
	);

	video_sync #(
		.h_total  (h_total),
		.h_sync   (h_sync),
		.hpix_beg (hpix_beg),
		.hpix_end (hpix_end),
		.v_total  (v_total),
		.v_sync   (v_sync),
		.vpix_beg (vpix_beg),
		.vpix_end (vpix_end)
	) video_sync (
		.clk       (clk),
		.arst_n    (arst_n),
		.regs      (regs),
		.raster    (raster),
		.hsync     (hsync),
		.vsync     (vsync),
		.csync     (csync),
		.int_start (int_start)
	);

	video_fetch #(
		.hpix_beg (hpix_beg),
		.hpix_end (hpix_end),
		.vpix_beg (vpix_beg),
		.vpix_end (vpix_end)
	) video_fetch (
		.clk          (clk),
		.arst_n       (arst_n),
		.raster       (raster),
		.regs         (regs),
		.video_go     (video_go),
		.video_addr   (video_addr),
		.video_strobe (video_strobe),
		.dram_rddata  (dram_rddata),
		.word         (word)
	);

	video_render video_render (
		.clk    (clk),
		.arst_n (arst_n),
		.raster (raster),
		.regs   (regs),
		.word   (word),
		.index  (index)
	);

	video_out video_out (
		.clk     (clk),
		.arst_n  (arst_n),
		.index   (index),
		.cram_we (cram_we),
		.zma     (zma),
		.zmd     (zmd),
		.vred    (vred),
		.vgrn    (vgrn),
		.vblu    (vblu)
	);

endmodule

`default_nettype wire

// File: test/video_tb.sv
`timescale 1ns/1ps
`default_nettype none

module video_tb;

	localparam int h_total = 64;
	localparam int h_sync = 4;
	localparam int hpix_beg = 16;
	localparam int hpix_end = 48;
	localparam int v_total = 24;
	localparam int v_sync = 2;
	localparam int vpix_beg = 6;
	localparam int vpix_end = 18;
	// tests take about nine frames
	localparam int max_cycles = 10 * h_total * v_total;

	localparam int sel_border = 0;
	localparam int sel_vpage = 1;
	localparam int sel_palsel = 2;
	localparam int sel_hint = 3;
	localparam int sel_vintl = 4;
	localparam int sel_vinth = 5;

	logic clk;
	logic arst_n;
	logic [7:0] d;
	logic border_wr;
	logic vpage_wr;
	logic palsel_wr;
	logic hint_beg_wr;
	logic vint_begl_wr;
	logic vint_begh_wr;
	logic cram_we;
	logic [7:0] zma;
	logic [14:0] zmd;
	logic video_strobe;
	logic [15:0] dram_rddata;
	wire video_go;
	wire [20:0] video_addr;
	wire hsync;
	wire vsync;
	wire csync;
	wire int_start;
	wire [1:0] vred;
	wire [1:0] vgrn;
	wire [1:0] vblu;

	// reference copies of memory, CRAM and registers
	logic [15:0] mem [65536];
	logic [1:0] lat_tab [1024];
	logic [14:0] cram_ref [256];
	logic [7:0] border_ref;
	logic [7:0] vp_next;
	logic [7:0] vp_live;
	logic [3:0] pal_next;
	logic [3:0] pal_live;
	logic [8:0] hint_ref;
	logic [8:0] vint_ref;
	logic pix_on;
	integer seed;
	int cycles = 0;

	// raster position seen at the outputs
	int x;
	int y;
	int frames;
	int int_cnt;
	int req_cnt;
	int lat_idx;
	int lat_left;
	logic synced;
	logic busy;
	logic hs_prev;
	logic vs_prev;
	logic [20:0] req_addr;

	video_top #(
		.h_total  (h_total),
		.h_sync   (h_sync),
		.hpix_beg (hpix_beg),
		.hpix_end (hpix_end),
		.v_total  (v_total),
		.v_sync   (v_sync),
		.vpix_beg (vpix_beg),
		.vpix_end (vpix_end)
	) dut (
		.clk          (clk),
		.arst_n       (arst_n),
		.d            (d),
		.border_wr    (border_wr),
		.vpage_wr     (vpage_wr),
		.palsel_wr    (palsel_wr),
		.hint_beg_wr  (hint_beg_wr),
		.vint_begl_wr (vint_begl_wr),
		.vint_begh_wr (vint_begh_wr),
		.cram_we      (cram_we),
		.zma          (zma),
		.zmd          (zmd),
		.video_go     (video_go),
		.video_addr   (video_addr),
		.video_strobe (video_strobe),
		.dram_rddata  (dram_rddata),
		.hsync        (hsync),
		.vsync        (vsync),
		.csync        (csync),
		.int_start    (int_start),
		.vred         (vred),
		.vgrn         (vgrn),
		.vblu         (vblu)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: tests still running after %0d cycles", cycles);
			$display("Finished with errors");
			$fatal(1);
		end
	end

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h, expected %h", name, got, exp);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	function automatic logic [20:0] word_addr(input logic [7:0] vp, input int row, input int idx);
		return 21'(int'(vp) * 8192 + (row - vpix_beg) * 64 + idx);
	endfunction

	task automatic pixel_check;
		logic [20:0] a;
		logic [15:0] w;
		logic [7:0] idx;
		logic [14:0] c;
		int px;
		if (x >= hpix_beg && x < hpix_end && y >= vpix_beg && y < vpix_end) begin
			px = x - hpix_beg;
			a = word_addr(vp_live, y, px / 4);
			w = mem[a[15:0]];
			// leftmost pixel in bits 15:12
			idx = {pal_live, 4'(w >> (12 - 4 * (px % 4)))};
		end else begin
			idx = border_ref;
		end
		c = cram_ref[idx];
		compare("vred", vred, c[14:13]);
		compare("vgrn", vgrn, c[9:8]);
		compare("vblu", vblu, c[4:3]);
	endtask

	// lines by hsync fall, frames by vsync fall
	task automatic monitor_step;
		if (arst_n) begin
			if (hs_prev && !hsync) begin
				if (synced) begin
					compare("hsync period", x + 1, h_total);
					compare("request count", req_cnt,
						(y >= vpix_beg && y < vpix_end) ? 8 : 0);
				end
				x = 0;
				req_cnt = 0;
				pal_live = pal_next;
				if (vs_prev && !vsync) begin
					if (synced)
						compare("vsync period", y + 1, v_total);
					y = 0;
					synced = 1'b1;
					frames = frames + 1;
					vp_live = vp_next;
				end else begin
					y = y + 1;
				end
			end else begin
				x = x + 1;
			end
			if (synced) begin
				compare("hsync", hsync, x >= h_sync);
				compare("vsync", vsync, y >= v_sync);
				compare("csync", csync, x >= h_sync && y >= v_sync);
				compare("int_start", int_start, x == hint_ref && y == vint_ref);
				if (int_start)
					int_cnt = int_cnt + 1;
				if (pix_on)
					pixel_check();
			end
		end
		hs_prev = hsync;
		vs_prev = vsync;
	endtask

	// DRAM with 1 to 3 cycles latency
	task automatic dram_step;
		video_strobe = 1'b0;
		if (!arst_n) begin
			busy = 1'b0;
		end else begin
			if (!busy && video_go) begin
				req_addr = video_addr;
				compare("video_addr", video_addr, word_addr(vp_live, y, req_cnt));
				req_cnt = req_cnt + 1;
				lat_left = lat_tab[lat_idx % 1024];
				lat_idx = lat_idx + 1;
				busy = 1'b1;
			end else if (busy) begin
				lat_left = lat_left - 1;
			end
			if (busy && lat_left == 0) begin
				video_strobe = 1'b1;
				dram_rddata = mem[req_addr[15:0]];
				busy = 1'b0;
			end
		end
	endtask

	initial begin
		video_strobe = 1'b0;
		dram_rddata = '0;
		x = 0;
		y = 0;
		frames = 0;
		int_cnt = 0;
		req_cnt = 0;
		lat_idx = 0;
		lat_left = 0;
		synced = 1'b0;
		busy = 1'b0;
		hs_prev = 1'b1;
		vs_prev = 1'b1;
		forever begin
			@(negedge clk);
			monitor_step();
			dram_step();
		end
	end

	task automatic wait_frame;
		int f;
		@(posedge clk);
		f = frames;
		while (frames == f)
			@(posedge clk);
	endtask

	task automatic wait_row(input int row);
		do @(posedge clk); while (y != row);
	endtask

	task automatic load_cram;
		for (int i = 0; i < 256; i++) begin
			@(negedge clk);
			cram_we = 1'b1;
			zma = 8'(i);
			zmd = 15'($random(seed));
			cram_ref[i] = zmd;
		end
		@(negedge clk);
		cram_we = 1'b0;
	endtask

	// writes land mid-line away from the line and frame strobes
	task automatic write_port(input int sel, input logic [7:0] val);
		do @(posedge clk); while (x != 30);
		@(negedge clk);
		d = val;
		case (sel)
			sel_border: begin
				border_wr = 1'b1;
				border_ref = val;
			end
			sel_vpage: begin
				vpage_wr = 1'b1;
				vp_next = val;
			end
			sel_palsel: begin
				palsel_wr = 1'b1;
				pal_next = val[3:0];
			end
			sel_hint: begin
				hint_beg_wr = 1'b1;
				hint_ref = {1'b0, val};
			end
			sel_vintl: begin
				vint_begl_wr = 1'b1;
				vint_ref[7:0] = val;
			end
			default: begin
				vint_begh_wr = 1'b1;
				vint_ref[8] = val[0];
			end
		endcase
		@(negedge clk);
		border_wr = 1'b0;
		vpage_wr = 1'b0;
		palsel_wr = 1'b0;
		hint_beg_wr = 1'b0;
		vint_begl_wr = 1'b0;
		vint_begh_wr = 1'b0;
	endtask

	task automatic reset_and_syncs;
		repeat (8) @(negedge clk);
		compare("hsync", hsync, 1'b1);
		compare("vsync", vsync, 1'b1);
		compare("csync", csync, 1'b1);
		compare("video_go", video_go, 1'b0);
		compare("int_start", int_start, 1'b0);
		compare("vred", vred, 2'd0);
		compare("vgrn", vgrn, 2'd0);
		compare("vblu", vblu, 2'd0);
		arst_n = 1'b1;
		// widths and periods checked along the way
		wait_frame();
		wait_frame();
	endtask

	task automatic border_colour;
		load_cram();
		write_port(sel_border, 8'h9c);
		wait_frame();
		pix_on = 1'b1;
		wait_frame();
	endtask

	task automatic active_pixels;
		write_port(sel_vpage, 8'h03);
		write_port(sel_palsel, 8'h05);
		wait_frame();
		wait_frame();
	endtask

	task automatic shadow_writes;
		wait_row(8);
		write_port(sel_palsel, 8'h0a);
		write_port(sel_vpage, 8'h06);
		wait_frame();
		wait_row(vpix_end);
	endtask

	task automatic frame_interrupt;
		int n;
		write_port(sel_hint, 8'd40);
		write_port(sel_vintl, 8'd9);
		// bit 8 set puts the match beyond the last row
		write_port(sel_vinth, 8'h01);
		wait_frame();
		wait_row(10);
		write_port(sel_vinth, 8'h00);
		wait_frame();
		n = int_cnt;
		wait_frame();
		compare("int_start count", int_cnt - n, 1);
	endtask

	initial begin
		seed = 32'hd9bc_9bbb;
		arst_n = 1'b0;
		d = '0;
		border_wr = 1'b0;
		vpage_wr = 1'b0;
		palsel_wr = 1'b0;
		hint_beg_wr = 1'b0;
		vint_begl_wr = 1'b0;
		vint_begh_wr = 1'b0;
		cram_we = 1'b0;
		zma = '0;
		zmd = '0;
		border_ref = '0;
		vp_next = '0;
		vp_live = '0;
		pal_next = '0;
		pal_live = '0;
		hint_ref = '0;
		vint_ref = '0;
		pix_on = 1'b0;
		for (int i = 0; i < 65536; i++)
			mem[i] = 16'($random(seed));
		for (int i = 0; i < 1024; i++)
			lat_tab[i] = 2'($unsigned($random(seed)) % 3);

		reset_and_syncs();
		border_colour();
		active_pixels();
		shadow_writes();
		frame_interrupt();

		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: video.f
verilog/video_pkg.sv
verilog/video_ports.sv
verilog/video_sync.sv
verilog/video_fetch.sv
verilog/video_render.sv
verilog/video_out.sv
verilog/video_top.sv
test/video_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the video testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f video.f --top-module video_tb -o video_sim
status=$?
if [ $status -ne 0 ]; then
	echo "compile failed"
	exit $status
fi

./obj_dir/video_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed"
	exit $status
fi

exit 0
